//--- hw/cache_geom_pkg.sv
package cache_geom_pkg;

    // set array
    localparam int SETS    = 256;
    localparam int INDEX_W = $clog2(SETS);  // 8

    // tag and word
    localparam int TAG_W  = 21;
    localparam int WORD_W = 32;

    // line layout, four word banks per way
    localparam int WORDS_PER_LINE = 4;
    localparam int OFFSET_W       = $clog2(WORDS_PER_LINE);
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;  // 128

    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [LINE_W-1:0]   line_t;

endpackage

//--- hw/cache_op_pkg.sv
package cache_op_pkg;

    // one operation per cycle, sampled every edge
    typedef enum logic [1:0] {
        OP_IDLE  = 2'd0,
        OP_READ  = 2'd1,   // both ways plus lru
        OP_FILL  = 2'd2,   // whole line from next level
        OP_STORE = 2'd3    // single word by offset
    } cache_op_e;

    typedef enum logic {
        WAY0 = 1'b0,
        WAY1 = 1'b1
    } way_e;

endpackage

//--- hw/ram_access_if.sv
interface ram_access_if;

    logic       we0;         // way 0 write
    logic       we1;         // way 1 write
    logic       re;          // read all banks
    logic       store_mode;  // word write, else line fill
    logic [7:0] index;
    logic [1:0] offset;      // word select for stores

    modport ctrl (
        output we0,
        output we1,
        output re,
        output store_mode,
        output index,
        output offset
    );

    modport store (
        input we0,
        input we1,
        input re,
        input store_mode,
        input index,
        input offset
    );

endinterface

//--- hw/sram_bank.sv
module sram_bank #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [7:0]       addr,
    input  logic             we,
    input  logic             re,
    input  logic [WIDTH-1:0] wd,
    output logic [WIDTH-1:0] rd
);

    logic [WIDTH-1:0] mem [0:255];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wd;
        end
    end

    // read register holds until the next read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd <= '0;
        end else if (re) begin
            rd <= mem[addr];  // old data on same-edge write
        end
    end

    a_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        (we || re) |-> !$isunknown(addr)
    );

endmodule

//--- hw/dcache_ctrl.sv
module dcache_ctrl
    import cache_geom_pkg::*;
    import cache_op_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  cache_op_e op,
    input  way_e      way,
    input  index_t    index,
    input  offset_t   offset,
    ram_access_if.ctrl acc,
    output logic      complete
);

    logic wr;  // fill or store this cycle

    always_comb begin
        wr             = (op == OP_FILL) || (op == OP_STORE);
        acc.we0        = wr && (way == WAY0);
        acc.we1        = wr && (way == WAY1);
        acc.re         = (op == OP_READ);
        acc.store_mode = (op == OP_STORE);
        acc.index      = index;
        acc.offset     = offset;
    end

    // one pulse per write, one cycle late
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            complete <= 1'b0;
        end else begin
            complete <= acc.we0 || acc.we1;
        end
    end

    a_one_way: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(acc.we0 && acc.we1)
    );

    a_complete_follows: assert property (
        @(posedge clk) disable iff (!rst_n)
        (op == OP_FILL || op == OP_STORE) |=> complete
    );

endmodule

//--- hw/tag_store.sv
module tag_store
    import cache_geom_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    ram_access_if.store acc,
    input  tag_t        tag_wd,
    input  logic        dirty_wd,
    output tag_t        tag0_rd,
    output tag_t        tag1_rd,
    output logic        dirty0,
    output logic        dirty1,
    output logic        lru
);

    logic lru_we;
    logic lru_wd;

    // way 0 written -> way 1 is least recent
    assign lru_we = acc.we0 || acc.we1;
    assign lru_wd = acc.we0;

    sram_bank #(.WIDTH(TAG_W)) i_tag0 (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (acc.index),
        .we    (acc.we0),
        .re    (acc.re),
        .wd    (tag_wd),
        .rd    (tag0_rd)
    );

    sram_bank #(.WIDTH(TAG_W)) i_tag1 (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (acc.index),
        .we    (acc.we1),
        .re    (acc.re),
        .wd    (tag_wd),
        .rd    (tag1_rd)
    );

    sram_bank #(.WIDTH(1)) i_dirty0 (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (acc.index),
        .we    (acc.we0),
        .re    (acc.re),
        .wd    (dirty_wd),
        .rd    (dirty0)
    );

    sram_bank #(.WIDTH(1)) i_dirty1 (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (acc.index),
        .we    (acc.we1),
        .re    (acc.re),
        .wd    (dirty_wd),
        .rd    (dirty1)
    );

    sram_bank #(.WIDTH(1)) i_lru (  // one bit per set
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (acc.index),
        .we    (lru_we),
        .re    (acc.re),
        .wd    (lru_wd),
        .rd    (lru)
    );

endmodule

//--- hw/data_store.sv
module data_store
    import cache_geom_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    ram_access_if.store acc,
    input  line_t       fill_line,
    input  word_t       store_word,
    output line_t       data0_rd,
    output line_t       data1_rd
);

    logic  way_we [2];
    word_t wd_word [WORDS_PER_LINE];
    line_t rd_line [2];

    assign way_we[0] = acc.we0;
    assign way_we[1] = acc.we1;

    // write data per word bank, shared by both ways
    for (genvar k = 0; k < WORDS_PER_LINE; k++) begin : g_wd
        assign wd_word[k] = acc.store_mode ? store_word
                                           : fill_line[k*WORD_W +: WORD_W];
    end

    for (genvar w = 0; w < 2; w++) begin : g_way
        for (genvar k = 0; k < WORDS_PER_LINE; k++) begin : g_word
            logic bank_we;

            // fill hits all banks, store only the addressed word
            assign bank_we = way_we[w]
                && (!acc.store_mode || acc.offset == offset_t'(k));

            sram_bank #(.WIDTH(WORD_W)) i_bank (
                .clk   (clk),
                .rst_n (rst_n),
                .addr  (acc.index),
                .we    (bank_we),
                .re    (acc.re),
                .wd    (wd_word[k]),
                .rd    (rd_line[w][k*WORD_W +: WORD_W])
            );
        end
    end

    assign data0_rd = rd_line[0];
    assign data1_rd = rd_line[1];

endmodule

//--- hw/dcache_ram.sv
module dcache_ram
    import cache_geom_pkg::*;
    import cache_op_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  cache_op_e op,
    input  way_e      way,
    input  index_t    index,
    input  offset_t   offset,
    input  tag_t      tag_wd,
    input  logic      dirty_wd,
    input  line_t     fill_line,
    input  word_t     store_word,
    output tag_t      tag0_rd,
    output tag_t      tag1_rd,
    output logic      dirty0,
    output logic      dirty1,
    output logic      lru,
    output line_t     data0_rd,
    output line_t     data1_rd,
    output logic      complete
);

    ram_access_if acc ();  // decoded strobes to both stores

    dcache_ctrl i_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .op       (op),
        .way      (way),
        .index    (index),
        .offset   (offset),
        .acc      (acc.ctrl),
        .complete (complete)
    );

    tag_store i_tag_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .acc      (acc.store),
        .tag_wd   (tag_wd),
        .dirty_wd (dirty_wd),
        .tag0_rd  (tag0_rd),
        .tag1_rd  (tag1_rd),
        .dirty0   (dirty0),
        .dirty1   (dirty1),
        .lru      (lru)
    );

    data_store i_data_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .acc        (acc.store),
        .fill_line  (fill_line),
        .store_word (store_word),
        .data0_rd   (data0_rd),
        .data1_rd   (data1_rd)
    );

endmodule

//--- sim/tb_dcache_ram.sv
module tb_dcache_ram
    import cache_geom_pkg::*;
    import cache_op_pkg::*;
();

    localparam int RESET_CYCLES   = 8;
    localparam int N_DIRECTED     = 20;
    localparam int N_RANDOM       = 400;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_DIRECTED + N_RANDOM + 100;

    logic      clk;
    logic      rst_n;
    cache_op_e op;
    way_e      way;
    index_t    index;
    offset_t   offset;
    tag_t      tag_wd;
    logic      dirty_wd;
    line_t     fill_line;
    word_t     store_word;
    tag_t      tag0_rd;
    tag_t      tag1_rd;
    logic      dirty0;
    logic      dirty1;
    logic      lru;
    line_t     data0_rd;
    line_t     data1_rd;
    logic      complete;

    // reference model, one entry per set and way
    tag_t  m_tag     [SETS][2];
    logic  m_dirty   [SETS][2];
    line_t m_line    [SETS][2];
    logic  m_lru     [SETS];
    logic  m_written [SETS][2];  // line filled at least once

    // read registers hold between reads
    tag_t  hold_tag   [2];
    logic  hold_dirty [2];
    logic  hold_lru;
    line_t hold_line  [2];

    logic   exp_complete;  // previous op was a write
    logic   pend_read;     // previous op was a read
    index_t pend_index;
    string  cur_test;
    string  issue_test;    // test that issued the previous op
    integer seed;
    int     errors;
    int     checks;

    dcache_ram i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .op         (op),
        .way        (way),
        .index      (index),
        .offset     (offset),
        .tag_wd     (tag_wd),
        .dirty_wd   (dirty_wd),
        .fill_line  (fill_line),
        .store_word (store_word),
        .tag0_rd    (tag0_rd),
        .tag1_rd    (tag1_rd),
        .dirty0     (dirty0),
        .dirty1     (dirty1),
        .lru        (lru),
        .data0_rd   (data0_rd),
        .data1_rd   (data1_rd),
        .complete   (complete)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(TIMEOUT_CYCLES * 8);
        $display("watchdog expired before the tests finished");
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic check_value(string what, line_t exp, line_t act);
        checks++;
        if (act !== exp) begin
            $display("Error: %s %s expected %0h got %0h", issue_test, what, exp, act);
            errors++;
        end
    endtask

    // sampled at the falling edge, half a cycle after the registers load
    task automatic check_outputs();
        if (pend_read) begin
            hold_tag[0]   = m_tag[pend_index][0];
            hold_tag[1]   = m_tag[pend_index][1];
            hold_dirty[0] = m_dirty[pend_index][0];
            hold_dirty[1] = m_dirty[pend_index][1];
            hold_lru      = m_lru[pend_index];
            hold_line[0]  = m_line[pend_index][0];
            hold_line[1]  = m_line[pend_index][1];
        end
        check_value("complete", line_t'(exp_complete), line_t'(complete));
        check_value("tag0", line_t'(hold_tag[0]), line_t'(tag0_rd));
        check_value("tag1", line_t'(hold_tag[1]), line_t'(tag1_rd));
        check_value("dirty0", line_t'(hold_dirty[0]), line_t'(dirty0));
        check_value("dirty1", line_t'(hold_dirty[1]), line_t'(dirty1));
        check_value("lru", line_t'(hold_lru), line_t'(lru));
        check_value("data0", hold_line[0], data0_rd);
        check_value("data1", hold_line[1], data1_rd);
    endtask

    task automatic issue(cache_op_e o, way_e w, index_t idx, offset_t off);
        int    wi;
        tag_t  t;
        logic  d;
        line_t l;
        word_t wd;
        wi = (w == WAY1) ? 1 : 0;
        t  = tag_t'($random(seed));
        d  = ($random(seed) & 1) != 0;
        l  = {$random(seed), $random(seed), $random(seed), $random(seed)};
        wd = $random(seed);
        @(negedge clk);
        check_outputs();
        op           = o;
        way          = w;
        index        = idx;
        offset       = off;
        tag_wd       = t;
        dirty_wd     = d;
        fill_line    = l;
        store_word   = wd;
        issue_test   = cur_test;
        exp_complete = (o == OP_FILL) || (o == OP_STORE);
        pend_read    = (o == OP_READ);
        pend_index   = idx;
        if (exp_complete) begin
            m_tag[idx][wi]   = t;
            m_dirty[idx][wi] = d;
            m_lru[idx]       = (w == WAY0);  // other way becomes least recent
            if (o == OP_FILL) begin
                m_line[idx][wi]    = l;
                m_written[idx][wi] = 1'b1;
            end else begin
                m_line[idx][wi][off*WORD_W +: WORD_W] = wd;
            end
        end
    endtask

    task automatic run_random();
        index_t  idx;
        way_e    w;
        offset_t off;
        int      sel;
        for (int i = 0; i < N_RANDOM; i++) begin
            idx = index_t'($random(seed) & 15);  // 16 sets
            w   = ($random(seed) & 1) ? WAY1 : WAY0;
            off = offset_t'($random(seed));
            sel = $random(seed) & 3;
            if (sel == 1 && !(m_written[idx][0] && m_written[idx][1])) begin
                sel = 2;  // read only fully filled sets
            end
            if (sel == 3 && !m_written[idx][(w == WAY1) ? 1 : 0]) begin
                sel = 2;
            end
            case (sel)
                0:       issue(OP_IDLE, w, idx, off);
                1:       issue(OP_READ, w, idx, off);
                2:       issue(OP_FILL, w, idx, off);
                default: issue(OP_STORE, w, idx, off);
            endcase
        end
    endtask

    initial begin
        seed         = 40;
        errors       = 0;
        checks       = 0;
        rst_n        = 1'b0;
        op           = OP_IDLE;
        way          = WAY0;
        index        = '0;
        offset       = '0;
        tag_wd       = '0;
        dirty_wd     = 1'b0;
        fill_line    = '0;
        store_word   = '0;
        exp_complete = 1'b0;
        pend_read    = 1'b0;
        pend_index   = '0;
        hold_tag[0]   = '0;
        hold_tag[1]   = '0;
        hold_dirty[0] = 1'b0;
        hold_dirty[1] = 1'b0;
        hold_lru      = 1'b0;
        hold_line[0]  = '0;
        hold_line[1]  = '0;
        cur_test     = "reset";
        issue_test   = "reset";
        for (int s = 0; s < SETS; s++) begin
            m_written[s][0] = 1'b0;
            m_written[s][1] = 1'b0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        check_value("complete", '0, line_t'(complete));
        check_value("tag0", '0, line_t'(tag0_rd));
        check_value("tag1", '0, line_t'(tag1_rd));
        check_value("dirty0", '0, line_t'(dirty0));
        check_value("dirty1", '0, line_t'(dirty1));
        check_value("lru", '0, line_t'(lru));
        check_value("data0", '0, data0_rd);
        check_value("data1", '0, data1_rd);

        cur_test = "fill";
        issue(OP_FILL, WAY0, 8'd3, 2'd0);
        issue(OP_FILL, WAY1, 8'd3, 2'd0);
        issue(OP_READ, WAY0, 8'd3, 2'd0);
        issue(OP_IDLE, WAY0, 8'd3, 2'd0);

        cur_test = "store";
        issue(OP_STORE, WAY1, 8'd3, 2'd2);
        issue(OP_READ, WAY0, 8'd3, 2'd0);
        issue(OP_STORE, WAY0, 8'd3, 2'd0);
        issue(OP_READ, WAY0, 8'd3, 2'd0);

        cur_test = "lru";
        issue(OP_FILL, WAY1, 8'd200, 2'd0);
        issue(OP_FILL, WAY0, 8'd200, 2'd0);
        issue(OP_READ, WAY0, 8'd200, 2'd0);  // expects 1
        issue(OP_STORE, WAY1, 8'd200, 2'd3);
        issue(OP_READ, WAY0, 8'd200, 2'd0);  // expects 0
        issue(OP_IDLE, WAY0, 8'd0, 2'd0);

        cur_test = "random";
        run_random();
        issue(OP_IDLE, WAY0, 8'd0, 2'd0);  // checks the last op
        @(negedge clk);
        check_outputs();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- compile.f
hw/cache_geom_pkg.sv
hw/cache_op_pkg.sv
hw/ram_access_if.sv
hw/sram_bank.sv
hw/dcache_ctrl.sv
hw/tag_store.sv
hw/data_store.sv
hw/dcache_ram.sv
sim/tb_dcache_ram.sv

//--- Makefile
VERILATOR  = verilator
TOP        = tb_dcache_ram
FILELIST   = compile.f
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
